//--- Makefile
# Verilator build and run of the max-pooling testbench

TOP = tb_pool_top

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	    -f project.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "test failed" sim.log; then \
	    echo "Simulation reported a failure, see sim.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- project.f
rtl/pool_pkg.sv
rtl/pool_stream_if.sv
rtl/line_buffer.sv
rtl/max_pool_unit.sv
rtl/pool_result_writer.sv
rtl/pool_top.sv
test/pool_assertions.sv
test/tb_pool_top.sv

//--- rtl/line_buffer.sv
module line_buffer #(
    parameter int IF_BW   = 8,
    parameter int IN_SIZE = 8,
    parameter int POOL_K  = 2,
    parameter int STRIDE  = 2
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             i_in_valid,
    input  logic [IF_BW-1:0] i_in_pixel,
    pool_stream_if.src       o_win
);

    localparam int XY_W     = pool_pkg::coord_w(IN_SIZE);
    localparam int OUT_SIZE = pool_pkg::out_size(IN_SIZE, POOL_K, STRIDE);
    localparam int OUT_W    = pool_pkg::coord_w(OUT_SIZE);
    localparam int NWIN     = POOL_K * POOL_K;

    logic [XY_W-1:0]  x_cnt;
    logic [XY_W-1:0]  y_cnt;

    // Row POOL_K holds the newest line, lower indices are older
    logic [IF_BW-1:0] line_mem [1:POOL_K][0:IN_SIZE-1];

    logic [NWIN-1:0][IF_BW-1:0] win_next;
    logic [NWIN-1:0][IF_BW-1:0] win_data;
    logic [OUT_W-1:0] win_x;
    logic [OUT_W-1:0] win_y;
    logic             win_valid;

    int   x_rel;
    int   y_rel;
    logic win_done;

    ////////////////////////////////////////////////////////////
    // Raster position of the incoming pixel
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (i_in_valid) begin
            if (int'(x_cnt) == IN_SIZE - 1) begin
                x_cnt <= '0;
                if (int'(y_cnt) == IN_SIZE - 1) begin
                    y_cnt <= '0;
                end else begin
                    y_cnt <= y_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    // Column x moves one row older, new pixel lands on top
    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int i = 1; i < POOL_K; i++) begin
                line_mem[i][x_cnt] <= line_mem[i + 1][x_cnt];
            end
            line_mem[POOL_K][x_cnt] <= i_in_pixel;
        end
    end

    ////////////////////////////////////////////////////////////
    // Window selection
    ////////////////////////////////////////////////////////////

    assign x_rel    = int'(x_cnt) - (POOL_K - 1);
    assign y_rel    = int'(y_cnt) - (POOL_K - 1);
    assign win_done = i_in_valid && (x_rel >= 0) && (y_rel >= 0)
                      && (x_rel % STRIDE == 0) && (y_rel % STRIDE == 0);

    // Entry wy*POOL_K+wx, oldest row and leftmost column first.
    // Column x is not yet written this cycle, so its rows sit one slot higher
    for (genvar wy = 0; wy < POOL_K; wy++) begin : g_row
        for (genvar wx = 0; wx < POOL_K; wx++) begin : g_col
            if (wy == POOL_K - 1 && wx == POOL_K - 1) begin : g_new
                assign win_next[wy*POOL_K + wx] = i_in_pixel;
            end else if (wx == POOL_K - 1) begin : g_cur
                assign win_next[wy*POOL_K + wx] = line_mem[wy + 2][x_cnt];
            end else begin : g_old
                assign win_next[wy*POOL_K + wx] =
                    line_mem[wy + 1][x_cnt - XY_W'(POOL_K - 1 - wx)];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            win_valid <= 1'b0;
        end else begin
            win_valid <= win_done;
        end
    end

    always_ff @(posedge clk) begin
        if (win_done) begin
            win_data <= win_next;
            win_x    <= OUT_W'(x_rel / STRIDE);
            win_y    <= OUT_W'(y_rel / STRIDE);
        end
    end

    assign o_win.valid   = win_valid;
    assign o_win.payload = win_data;
    assign o_win.out_x   = win_x;
    assign o_win.out_y   = win_y;

endmodule

//--- rtl/max_pool_unit.sv
module max_pool_unit #(
    parameter int IF_BW   = 8,
    parameter int POOL_K  = 2,
    parameter int COORD_W = pool_pkg::coord_w(
        pool_pkg::out_size(pool_pkg::DEF_IN_SIZE, pool_pkg::DEF_POOL_K, pool_pkg::DEF_STRIDE))
) (
    input logic        clk,
    input logic        reset_n,
    pool_stream_if.dst i_win,
    pool_stream_if.src o_max
);

    localparam int NWIN   = POOL_K * POOL_K;
    // Tree is padded to a power of two with zero leaves
    localparam int LEAVES = 2 ** $clog2(NWIN);

    logic [NWIN-1:0][IF_BW-1:0] win;
    logic [IF_BW-1:0]           node [0:2*LEAVES-2];

    logic               max_valid;
    logic [IF_BW-1:0]   max_data;
    logic [COORD_W-1:0] max_x;
    logic [COORD_W-1:0] max_y;

    assign win = i_win.payload;

    ////////////////////////////////////////////////////////////
    // Compare tree, node n takes children 2n+1 and 2n+2
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < LEAVES; j++) begin
            node[LEAVES - 1 + j] = '0;
        end
        for (int j = 0; j < NWIN; j++) begin
            node[LEAVES - 1 + j] = win[j];
        end
        for (int n = LEAVES - 2; n >= 0; n--) begin
            node[n] = (node[2*n + 1] >= node[2*n + 2]) ? node[2*n + 1] : node[2*n + 2];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            max_valid <= 1'b0;
        end else begin
            max_valid <= i_win.valid;
        end
    end

    // Coordinates ride along with the result
    always_ff @(posedge clk) begin
        if (i_win.valid) begin
            max_data <= node[0];
            max_x    <= i_win.out_x;
            max_y    <= i_win.out_y;
        end
    end

    assign o_max.valid   = max_valid;
    assign o_max.payload = max_data;
    assign o_max.out_x   = max_x;
    assign o_max.out_y   = max_y;

endmodule

//--- rtl/pool_pkg.sv
package pool_pkg;

    ////////////////////////////////////////////////////////////
    // Default geometry of the pooling stage
    ////////////////////////////////////////////////////////////

    // Pixel width in bits
    localparam int DEF_IF_BW   = 8;
    // Side of the square input map
    localparam int DEF_IN_SIZE = 8;
    // Side of the pooling window
    localparam int DEF_POOL_K  = 2;
    localparam int DEF_STRIDE  = 2;

    ////////////////////////////////////////////////////////////
    // Geometry helpers
    ////////////////////////////////////////////////////////////

    // Side of the pooled map, windows fully inside the input only
    function automatic int out_size(input int in_size, input int pool_k, input int stride);
        return (in_size - pool_k) / stride + 1;
    endfunction

    // Counter width for a given map side, at least one bit
    function automatic int coord_w(input int size);
        return (size > 1) ? $clog2(size) : 1;
    endfunction

endpackage

//--- rtl/pool_result_writer.sv
module pool_result_writer #(
    parameter  int IF_BW    = 8,
    parameter  int IN_SIZE  = 8,
    parameter  int POOL_K   = 2,
    parameter  int STRIDE   = 2,
    localparam int OUT_SIZE = pool_pkg::out_size(IN_SIZE, POOL_K, STRIDE),
    localparam int ADDR_W   = pool_pkg::coord_w(OUT_SIZE * OUT_SIZE)
) (
    input  logic              clk,
    input  logic              reset_n,
    pool_stream_if.dst        i_max,
    output logic              o_pool_valid,
    output logic [IF_BW-1:0]  o_pool_pixel,
    output logic [ADDR_W-1:0] o_pool_addr,
    output logic              o_frame_done
);

    logic [ADDR_W-1:0] addr_next;
    logic              last_pos;

    // Raster address in the pooled map
    assign addr_next = ADDR_W'(int'(i_max.out_y) * OUT_SIZE + int'(i_max.out_x));

    // Bottom right corner closes the frame
    assign last_pos  = (int'(i_max.out_x) == OUT_SIZE - 1)
                       && (int'(i_max.out_y) == OUT_SIZE - 1);

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_pool_valid <= 1'b0;
            o_pool_pixel <= '0;
            o_pool_addr  <= '0;
            o_frame_done <= 1'b0;
        end else begin
            o_pool_valid <= i_max.valid;
            o_frame_done <= i_max.valid && last_pos;
            if (i_max.valid) begin
                o_pool_pixel <= i_max.payload;
                o_pool_addr  <= addr_next;
            end
        end
    end

endmodule

//--- rtl/pool_stream_if.sv
interface pool_stream_if #(
    parameter type payload_t = logic,
    parameter int  COORD_W   = 1
);

    // Single-cycle strobe, everything below is valid with it
    logic               valid;
    logic [COORD_W-1:0] out_x;
    logic [COORD_W-1:0] out_y;
    payload_t           payload;

    // Producing stage
    modport src (
        output valid,
        output payload,
        output out_x,
        output out_y
    );

    // Consuming stage, takes every strobe
    modport dst (
        input valid,
        input payload,
        input out_x,
        input out_y
    );

endinterface

//--- rtl/pool_top.sv
module pool_top #(
    parameter  int IF_BW    = pool_pkg::DEF_IF_BW,
    parameter  int IN_SIZE  = pool_pkg::DEF_IN_SIZE,
    parameter  int POOL_K   = pool_pkg::DEF_POOL_K,
    parameter  int STRIDE   = pool_pkg::DEF_STRIDE,
    localparam int OUT_SIZE = pool_pkg::out_size(IN_SIZE, POOL_K, STRIDE),
    localparam int ADDR_W   = pool_pkg::coord_w(OUT_SIZE * OUT_SIZE)
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              i_in_valid,
    input  logic [IF_BW-1:0]  i_in_pixel,
    output logic              o_pool_valid,
    output logic [IF_BW-1:0]  o_pool_pixel,
    output logic [ADDR_W-1:0] o_pool_addr,
    output logic              o_frame_done
);

    localparam int COORD_W = pool_pkg::coord_w(OUT_SIZE);

    // Payloads of the two internal buses
    typedef logic [POOL_K*POOL_K-1:0][IF_BW-1:0] win_t;
    typedef logic [IF_BW-1:0] pix_t;

    pool_stream_if #(.payload_t(win_t), .COORD_W(COORD_W)) win_bus ();
    pool_stream_if #(.payload_t(pix_t), .COORD_W(COORD_W)) max_bus ();

    ////////////////////////////////////////////////////////////
    // Decode, execute and result stages
    ////////////////////////////////////////////////////////////

    line_buffer #(
        .IF_BW  (IF_BW),
        .IN_SIZE(IN_SIZE),
        .POOL_K (POOL_K),
        .STRIDE (STRIDE)
    ) u_line_buffer (
        .clk       (clk),
        .reset_n   (reset_n),
        .i_in_valid(i_in_valid),
        .i_in_pixel(i_in_pixel),
        .o_win     (win_bus.src)
    );

    max_pool_unit #(
        .IF_BW  (IF_BW),
        .POOL_K (POOL_K),
        .COORD_W(COORD_W)
    ) u_max_pool_unit (
        .clk    (clk),
        .reset_n(reset_n),
        .i_win  (win_bus.dst),
        .o_max  (max_bus.src)
    );

    pool_result_writer #(
        .IF_BW  (IF_BW),
        .IN_SIZE(IN_SIZE),
        .POOL_K (POOL_K),
        .STRIDE (STRIDE)
    ) u_pool_result_writer (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_max       (max_bus.dst),
        .o_pool_valid(o_pool_valid),
        .o_pool_pixel(o_pool_pixel),
        .o_pool_addr (o_pool_addr),
        .o_frame_done(o_frame_done)
    );

endmodule

//--- test/pool_assertions.sv
module pool_assertions #(
    parameter int IF_BW    = 8,
    parameter int OUT_SIZE = 4,
    parameter int ADDR_W   = 4
) (
    input logic              clk,
    input logic              reset_n,
    input logic              i_in_valid,
    input logic              o_pool_valid,
    input logic [IF_BW-1:0]  o_pool_pixel,
    input logic [ADDR_W-1:0] o_pool_addr,
    input logic              o_frame_done
);

    // Frame end only ever rides on a result
    a_done_with_valid: assert property (@(posedge clk) disable iff (!reset_n)
        o_frame_done |-> o_pool_valid)
        else $error("frame done without a valid result");

    a_addr_range: assert property (@(posedge clk) disable iff (!reset_n)
        o_pool_valid |-> (int'(o_pool_addr) < OUT_SIZE * OUT_SIZE))
        else $error("result address outside the pooled map");

    // Three register stages from accepting edge to output
    a_latency: assert property (@(posedge clk) disable iff (!reset_n)
        o_pool_valid |-> $past(i_in_valid, 3))
        else $error("result without an input pixel three cycles earlier");

    a_no_x: assert property (@(posedge clk) disable iff (!reset_n)
        o_pool_valid |-> !$isunknown({o_pool_pixel, o_pool_addr, o_frame_done}))
        else $error("unknown value on the outputs of a valid result");

endmodule

bind pool_top pool_assertions #(
    .IF_BW   (IF_BW),
    .OUT_SIZE(OUT_SIZE),
    .ADDR_W  (ADDR_W)
) u_pool_assertions (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_in_valid  (i_in_valid),
    .o_pool_valid(o_pool_valid),
    .o_pool_pixel(o_pool_pixel),
    .o_pool_addr (o_pool_addr),
    .o_frame_done(o_frame_done)
);

//--- test/tb_pool_top.sv
module tb_pool_top;

    localparam int IF_BW        = pool_pkg::DEF_IF_BW;
    localparam int IN_SIZE      = pool_pkg::DEF_IN_SIZE;
    localparam int POOL_K       = pool_pkg::DEF_POOL_K;
    localparam int STRIDE       = pool_pkg::DEF_STRIDE;
    localparam int OUT_SIZE     = pool_pkg::out_size(IN_SIZE, POOL_K, STRIDE);
    localparam int ADDR_W       = pool_pkg::coord_w(OUT_SIZE * OUT_SIZE);
    localparam int CLK_PERIOD   = 8;
    localparam int NUM_FRAMES   = 5;
    localparam int TOTAL_PIXELS = NUM_FRAMES * IN_SIZE * IN_SIZE;

    typedef logic [IF_BW-1:0]  pix_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef struct packed {
        pix_t  pixel;
        addr_t addr;
        logic  done;
    } expect_t;

    logic        clk;
    logic        reset_n;
    logic        i_in_valid;
    pix_t        i_in_pixel;
    logic        o_pool_valid;
    pix_t        o_pool_pixel;
    addr_t       o_pool_addr;
    logic        o_frame_done;

    logic [31:0] seed;
    pix_t        frame_pix [0:IN_SIZE-1][0:IN_SIZE-1];
    expect_t     exp_q [$];
    int          done_count;

    pool_top #(
        .IF_BW  (IF_BW),
        .IN_SIZE(IN_SIZE),
        .POOL_K (POOL_K),
        .STRIDE (STRIDE)
    ) uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_in_valid  (i_in_valid),
        .i_in_pixel  (i_in_pixel),
        .o_pool_valid(o_pool_valid),
        .o_pool_pixel(o_pool_pixel),
        .o_pool_addr (o_pool_addr),
        .o_frame_done(o_frame_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////////////////////////////////////////////
    // Failure reporting and typed compares
    ////////////////////////////////////////////////////////////

    task automatic fail_run();
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input pix_t got, input pix_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_done(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model and stimulus
    ////////////////////////////////////////////////////////////

    // Store the pixel, then queue a result if it closes a window
    task automatic model_pixel(input int x, input int y, input pix_t pix);
        int      xr;
        int      yr;
        pix_t    best;
        expect_t e;
        frame_pix[y][x] = pix;
        xr = x - (POOL_K - 1);
        yr = y - (POOL_K - 1);
        if (xr >= 0 && yr >= 0 && xr % STRIDE == 0 && yr % STRIDE == 0) begin
            best = '0;
            for (int wy = yr; wy <= y; wy++) begin
                for (int wx = xr; wx <= x; wx++) begin
                    if (frame_pix[wy][wx] > best) begin
                        best = frame_pix[wy][wx];
                    end
                end
            end
            e.pixel = best;
            e.addr  = addr_t'((yr / STRIDE) * OUT_SIZE + xr / STRIDE);
            e.done  = (xr / STRIDE == OUT_SIZE - 1) && (yr / STRIDE == OUT_SIZE - 1);
            exp_q.push_back(e);
        end
    endtask

    // Fill 0 is random, 1 all zero, 2 all ones
    task automatic drive_frame(input int fill, input bit gaps);
        int   gap;
        pix_t pix;
        for (int y = 0; y < IN_SIZE; y++) begin
            for (int x = 0; x < IN_SIZE; x++) begin
                gap = 0;
                if (gaps) begin
                    seed = lcg_step(seed);
                    gap  = int'(seed[29:28]) % 3;
                end
                // Idle cycles carry junk that must be ignored
                repeat (gap) begin
                    @(negedge clk);
                    i_in_valid = 1'b0;
                    i_in_pixel = seed[15:8];
                end
                case (fill)
                    0: begin
                        seed = lcg_step(seed);
                        pix  = seed[31:24];
                    end
                    1: pix = '0;
                    default: pix = '1;
                endcase
                @(negedge clk);
                i_in_valid = 1'b1;
                i_in_pixel = pix;
                model_pixel(x, y, pix);
            end
        end
    endtask

    // Monitor, one queued entry per result
    always @(negedge clk) begin : monitor
        expect_t e;
        if (reset_n && o_pool_valid) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: result appeared with no window expected", $time);
                fail_run();
            end else begin
                e = exp_q.pop_front();
                check_pixel("o_pool_pixel", o_pool_pixel, e.pixel);
                check_addr("o_pool_addr", o_pool_addr, e.addr);
                check_done("o_frame_done", o_frame_done, e.done);
                if (o_frame_done) begin
                    done_count++;
                end
            end
        end
    end

    initial begin : watchdog
        #(4 * TOTAL_PIXELS * CLK_PERIOD);
        $display("Error at %0t: watchdog expired before the run finished", $time);
        fail_run();
    end

    initial begin
        clk        = 1'b0;
        reset_n    = 1'b0;
        i_in_valid = 1'b0;
        i_in_pixel = '0;
        seed       = 32'd93661;
        done_count = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Idle after reset, outputs stay at zero
        repeat (10) begin
            @(negedge clk);
            check_done("o_pool_valid", o_pool_valid, 1'b0);
            check_done("o_frame_done", o_frame_done, 1'b0);
            check_pixel("o_pool_pixel", o_pool_pixel, '0);
            check_addr("o_pool_addr", o_pool_addr, '0);
        end

        // Frames follow each other with no idle between them
        drive_frame(0, 1'b0);
        drive_frame(0, 1'b1);
        drive_frame(1, 1'b0);
        drive_frame(2, 1'b0);
        drive_frame(0, 1'b1);
        @(negedge clk);
        i_in_valid = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);

        if (done_count != NUM_FRAMES) begin
            $display("Error at %0t: saw %0d frame ends, expected %0d",
                     $time, done_count, NUM_FRAMES);
            fail_run();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
